// File: spi_loop_pkg.sv
// SPI loopback self-test shared types, sizes and state encodings
package spi_loop_pkg;

    localparam int num_lanes = 4;                 // Master/slave pairs
    localparam int data_w    = 8;                 // Bits per transfer
    localparam int baud_w    = 16;                // Divider width
    localparam int edge_w    = $clog2(2 * data_w); // SCK edge counter
    localparam int bit_w     = $clog2(data_w);     // Slave bit counter

    // Bit 1 is CPOL, bit 0 is CPHA
    typedef enum logic [1:0] {
        mode0 = 2'b00,  // Idle low, sample leading
        mode1 = 2'b01,  // Idle low, sample trailing
        mode2 = 2'b10,  // Idle high, sample leading
        mode3 = 2'b11   // Idle high, sample trailing
    } spi_mode_e;

    typedef enum logic [1:0] {
        m_idle,
        m_lead,   // Half period of setup after CS low
        m_shift,  // 2*data_w SCK edges
        m_done    // Half period tail, then done pulse
    } master_state_e;

    typedef enum logic [1:0] {
        s_idle,
        s_shift,
        s_done    // Byte captured, wait for CS high
    } slave_state_e;

    typedef enum logic [1:0] {
        c_idle,
        c_wait,   // Some lanes reported
        c_report  // run_done cycle
    } collector_state_e;

    // Bytes sent each way on one lane
    typedef struct packed {
        logic [data_w-1:0] master_tx;
        logic [data_w-1:0] slave_tx;
    } lane_pattern_t;

    typedef struct packed {
        logic [data_w-1:0] master_rx;  // Byte seen by master
        logic [data_w-1:0] slave_rx;   // Byte seen by slave
        logic              pass;       // Both directions matched
    } lane_result_t;

    typedef struct packed {
        spi_mode_e         mode;
        logic [baud_w-1:0] baud_div;   // Half SCK period is baud_div+1 clocks
    } run_cfg_t;

endpackage

// File: spi_master.sv
// SPI master for one byte with programmable divider and all four modes
`timescale 1ns/100ps

module spi_master (
    input  logic                            pll_clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  spi_loop_pkg::run_cfg_t          cfg,
    input  logic [spi_loop_pkg::data_w-1:0] tx_data,
    input  logic                            miso,
    output logic                            sclk,
    output logic                            mosi,
    output logic [spi_loop_pkg::data_w-1:0] rx_data,
    output logic                            done
);
    import spi_loop_pkg::*;

    master_state_e     state;
    logic [1:0]        mode_bits;
    logic              cpol;
    logic              cpha;
    logic [baud_w-1:0] div_cnt;
    logic              tick;       // End of a half period
    logic [edge_w-1:0] edge_cnt;
    logic              lead_edge;  // Next toggle leaves the idle level
    logic              launch;
    logic              capture;
    logic              capture_q;  // Sample one clock after the edge
    logic [data_w-1:0] tx_sh;
    logic [data_w-1:0] rx_sh;

    assign mode_bits = cfg.mode;
    assign cpol      = mode_bits[1];
    assign cpha      = mode_bits[0];
    assign tick      = (div_cnt == cfg.baud_div);
    assign lead_edge = ~edge_cnt[0];  // Even edges lead

    // CPHA 1 launches on leading edges, CPHA 0 on trailing
    assign launch  = (state == m_shift) && tick && (lead_edge == cpha);
    assign capture = (state == m_shift) && tick && (lead_edge != cpha);

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= m_idle;
            div_cnt   <= '0;
            edge_cnt  <= '0;
            sclk      <= 1'b0;
            mosi      <= 1'b0;
            done      <= 1'b0;
            capture_q <= 1'b0;
        end else begin
            done      <= 1'b0;
            capture_q <= capture;  // Gives the oversampled slave time to answer
            if (state == m_idle || tick)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;

            case (state)
                m_idle: begin
                    sclk     <= cpol;  // Follow idle level of latched mode
                    mosi     <= 1'b0;
                    edge_cnt <= '0;
                    if (start) begin
                        mosi  <= cpha ? 1'b0 : tx_data[data_w-1];  // MSB up front
                        state <= m_lead;
                    end
                end
                m_lead: begin
                    if (tick)
                        state <= m_shift;
                end
                m_shift: begin
                    if (tick) begin
                        sclk     <= ~sclk;
                        edge_cnt <= edge_cnt + 1'b1;
                        if (launch)
                            mosi <= tx_sh[data_w-1];
                        if (edge_cnt == edge_w'(2 * data_w - 1))
                            state <= m_done;  // SCK back at idle
                    end
                end
                m_done: begin
                    if (tick) begin
                        done  <= 1'b1;
                        state <= m_idle;
                    end
                end
                default: state <= m_idle;
            endcase
        end
    end

    // Data path
    always_ff @(posedge pll_clk) begin
        if (state == m_idle && start)
            tx_sh <= cpha ? tx_data : {tx_data[data_w-2:0], 1'b0};  // MSB already on mosi
        else if (launch)
            tx_sh <= {tx_sh[data_w-2:0], 1'b0};
        if (capture_q)
            rx_sh <= {rx_sh[data_w-2:0], miso};  // MSB first
        if (state == m_done && tick)
            rx_data <= rx_sh;  // Stable with done
    end

endmodule

// File: spi_slave.sv
// SPI slave for one byte, oversampled in the system clock domain
`timescale 1ns/100ps

module spi_slave (
    input  logic                            pll_clk,
    input  logic                            rst_n,
    input  spi_loop_pkg::run_cfg_t          cfg,
    input  logic                            sclk,
    input  logic                            mosi,
    input  logic                            cs,
    input  logic [spi_loop_pkg::data_w-1:0] tx_data,
    output logic                            miso,
    output logic [spi_loop_pkg::data_w-1:0] rx_data,
    output logic                            done
);
    import spi_loop_pkg::*;

    slave_state_e      state;
    logic [1:0]        mode_bits;
    logic              cpol;
    logic              cpha;
    logic [2:0]        sclk_sync;  // Two sync flops plus history
    logic [1:0]        mosi_sync;
    logic              sclk_s;
    logic              sclk_d;
    logic              sclk_idle;  // SCK settled at idle level
    logic              lead_edge;
    logic              trail_edge;
    logic              launch;
    logic              capture;
    logic              last_bit;
    logic [bit_w-1:0]  bit_cnt;
    logic [data_w-1:0] tx_sh;
    logic [data_w-1:0] rx_sh;

    assign mode_bits = cfg.mode;
    assign cpol      = mode_bits[1];
    assign cpha      = mode_bits[0];
    assign sclk_s    = sclk_sync[1];
    assign sclk_d    = sclk_sync[2];
    assign sclk_idle = (sclk_s == cpol) && (sclk_d == cpol);

    // Leading edge moves away from CPOL
    assign lead_edge  = (sclk_s != sclk_d) && (sclk_s != cpol);
    assign trail_edge = (sclk_s != sclk_d) && (sclk_s == cpol);
    assign launch     = (state == s_shift) && (cpha ? lead_edge : trail_edge);
    assign capture    = (state == s_shift) && (cpha ? trail_edge : lead_edge);
    assign last_bit   = (bit_cnt == bit_w'(data_w - 1));

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_sync <= '0;
            mosi_sync <= '0;
            state     <= s_idle;
            bit_cnt   <= '0;
            miso      <= 1'b0;
            done      <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[1:0], sclk};
            mosi_sync <= {mosi_sync[0], mosi};
            done      <= 1'b0;
            case (state)
                s_idle: begin
                    miso    <= 1'b0;
                    bit_cnt <= '0;
                    // Wait out any idle level change from a mode switch
                    if (!cs && sclk_idle) begin
                        miso  <= cpha ? 1'b0 : tx_data[data_w-1];
                        state <= s_shift;
                    end
                end
                s_shift: begin
                    if (cs) begin
                        state <= s_idle;  // Aborted frame
                    end else begin
                        if (launch)
                            miso <= tx_sh[data_w-1];
                        if (capture) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (last_bit) begin
                                done  <= 1'b1;
                                state <= s_done;
                            end
                        end
                    end
                end
                s_done: begin
                    if (cs)
                        state <= s_idle;  // Extra trailing edge ignored here
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge pll_clk) begin
        if (state == s_idle)
            tx_sh <= cpha ? tx_data : {tx_data[data_w-2:0], 1'b0};
        else if (launch)
            tx_sh <= {tx_sh[data_w-2:0], 1'b0};
        if (capture)
            rx_sh <= {rx_sh[data_w-2:0], mosi_sync[1]};
        if (capture && last_bit)
            rx_data <= {rx_sh[data_w-2:0], mosi_sync[1]};  // Include eighth bit
    end

endmodule

// File: loop_sequencer.sv
// Run controller latching configuration and patterns and owning chip select
`timescale 1ns/100ps

module loop_sequencer (
    input  logic                                                      pll_clk,
    input  logic                                                      rst_n,
    input  logic                                                      start,
    input  spi_loop_pkg::run_cfg_t                                    cfg_in,
    input  spi_loop_pkg::lane_pattern_t [spi_loop_pkg::num_lanes-1:0] patterns_in,
    input  logic                                                      end_run,
    output spi_loop_pkg::run_cfg_t                                    cfg,
    output spi_loop_pkg::lane_pattern_t [spi_loop_pkg::num_lanes-1:0] patterns,
    output logic                                                      lane_start,
    output logic                                                      cs,
    output logic                                                      busy
);
    import spi_loop_pkg::*;

    logic accept;

    assign accept = start && !busy;  // Starts during a run are dropped

    // busy is the run state, idle or running
    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            cs         <= 1'b1;
            lane_start <= 1'b0;
            cfg        <= '{mode: mode0, baud_div: '0};  // SCK idles low out of reset
        end else begin
            lane_start <= accept;  // One clock pulse, same cycle as CS low
            if (accept) begin
                busy <= 1'b1;
                cs   <= 1'b0;
                cfg  <= cfg_in;
            end else if (end_run) begin
                busy <= 1'b0;
                cs   <= 1'b1;  // Rises with run_done
            end
        end
    end

    // Patterns held for the masters, slaves and collector
    always_ff @(posedge pll_clk) begin
        if (accept)
            patterns <= patterns_in;
    end

endmodule

// File: loop_result_collector.sv
// Collects lane completions and compares received bytes both ways
`timescale 1ns/100ps

module loop_result_collector (
    input  logic                                                          pll_clk,
    input  logic                                                          rst_n,
    input  spi_loop_pkg::lane_pattern_t [spi_loop_pkg::num_lanes-1:0]     patterns,
    input  logic [spi_loop_pkg::num_lanes-1:0]                            m_done,
    input  logic [spi_loop_pkg::num_lanes-1:0][spi_loop_pkg::data_w-1:0]  m_rx,
    input  logic [spi_loop_pkg::num_lanes-1:0][spi_loop_pkg::data_w-1:0]  s_rx,
    output spi_loop_pkg::lane_result_t [spi_loop_pkg::num_lanes-1:0]      results,
    output logic                                                          end_run,
    output logic                                                          run_done
);
    import spi_loop_pkg::*;

    collector_state_e               state;
    logic [num_lanes-1:0]           done_mask;  // Sticky per lane
    logic [num_lanes-1:0]           mask_next;
    lane_result_t [num_lanes-1:0]   check;

    assign mask_next = done_mask | m_done;
    // Combinational so CS rises in the same cycle as run_done
    assign end_run   = (state != c_report) && (&mask_next);

    always_comb begin
        for (int k = 0; k < num_lanes; k++) begin
            check[k].master_rx = m_rx[k];
            check[k].slave_rx  = s_rx[k];
            check[k].pass      = (m_rx[k] == patterns[k].slave_tx) &&
                                 (s_rx[k] == patterns[k].master_tx);  // Crossed compare
        end
    end

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= c_idle;
            done_mask <= '0;
            run_done  <= 1'b0;
            results   <= '0;
        end else begin
            run_done <= end_run;
            if (end_run)
                results <= check;  // Held until next run
            case (state)
                c_idle: begin
                    done_mask <= m_done;
                    if (end_run)
                        state <= c_report;  // All lanes in one cycle
                    else if (|m_done)
                        state <= c_wait;
                end
                c_wait: begin
                    done_mask <= mask_next;
                    if (end_run)
                        state <= c_report;
                end
                c_report: begin
                    done_mask <= '0;
                    state     <= c_idle;
                end
                default: state <= c_idle;
            endcase
        end
    end

endmodule

// File: spi_loop_top.sv
// SPI loopback self-test top with sequencer, master/slave lanes and collector
`timescale 1ns/100ps

module spi_loop_top (
    input  logic                                                      pll_clk,
    input  logic                                                      rst_n,
    input  logic                                                      start,
    input  spi_loop_pkg::run_cfg_t                                    cfg,
    input  spi_loop_pkg::lane_pattern_t [spi_loop_pkg::num_lanes-1:0] patterns,
    input  logic                                                      ext_loop,
    input  logic                                                      miso,
    output logic                                                      sclk,
    output logic                                                      mosi,
    output logic                                                      cs,
    output spi_loop_pkg::lane_result_t [spi_loop_pkg::num_lanes-1:0]  results,
    output logic                                                      run_done,
    output logic                                                      busy
);
    import spi_loop_pkg::*;

    run_cfg_t                         run_cfg;       // Latched for the run
    lane_pattern_t [num_lanes-1:0]    run_patterns;
    logic                             lane_start;
    logic                             end_run;
    logic [num_lanes-1:0]             lane_sclk;
    logic [num_lanes-1:0]             lane_mosi;
    logic [num_lanes-1:0]             slave_miso;
    logic [num_lanes-1:0]             master_miso;
    logic [num_lanes-1:0]             m_done;
    logic [num_lanes-1:0][data_w-1:0] m_rx;
    logic [num_lanes-1:0][data_w-1:0] s_rx;

    loop_sequencer u_seq (
        .pll_clk    (pll_clk),
        .rst_n      (rst_n),
        .start      (start),
        .cfg_in     (cfg),
        .patterns_in(patterns),
        .end_run    (end_run),
        .cfg        (run_cfg),
        .patterns   (run_patterns),
        .lane_start (lane_start),
        .cs         (cs),
        .busy       (busy)
    );

    for (genvar k = 0; k < num_lanes; k++) begin : g_lane
        // Lane 0 can loop through the external pins
        assign master_miso[k] = (k == 0 && ext_loop) ? miso : slave_miso[k];

        spi_master u_master (
            .pll_clk(pll_clk),
            .rst_n  (rst_n),
            .start  (lane_start),  // All lanes start together
            .cfg    (run_cfg),
            .tx_data(run_patterns[k].master_tx),
            .miso   (master_miso[k]),
            .sclk   (lane_sclk[k]),
            .mosi   (lane_mosi[k]),
            .rx_data(m_rx[k]),
            .done   (m_done[k])
        );

        spi_slave u_slave (
            .pll_clk(pll_clk),
            .rst_n  (rst_n),
            .cfg    (run_cfg),
            .sclk   (lane_sclk[k]),
            .mosi   (lane_mosi[k]),
            .cs     (cs),          // Shared chip select
            .tx_data(run_patterns[k].slave_tx),
            .miso   (slave_miso[k]),
            .rx_data(s_rx[k]),
            .done   ()             // Master done marks end of lane
        );
    end

    loop_result_collector u_collect (
        .pll_clk (pll_clk),
        .rst_n   (rst_n),
        .patterns(run_patterns),
        .m_done  (m_done),
        .m_rx    (m_rx),
        .s_rx    (s_rx),
        .results (results),
        .end_run (end_run),
        .run_done(run_done)
    );

    assign sclk = lane_sclk[0];  // Pins show lane 0
    assign mosi = lane_mosi[0];

endmodule

// File: spi_loop_checker.sv
// Bound assertions on chip select, lane start, busy and run_done of the loopback top
`timescale 1ns/100ps

module spi_loop_checker (
    input logic pll_clk,
    input logic rst_n,
    input logic lane_start,
    input logic cs,
    input logic busy,
    input logic run_done
);

    // Lane start lasts one clock
    a_start_pulse: assert property (@(posedge pll_clk) disable iff (!rst_n)
        lane_start |=> !lane_start)
        else $error("lane_start held for more than one cycle");

    a_start_cs: assert property (@(posedge pll_clk) disable iff (!rst_n)
        lane_start |-> (!cs && busy))  // CS already low at launch
        else $error("lane_start without chip select low and busy");

    // CS goes high only with the run_done pulse
    a_cs_rise: assert property (@(posedge pll_clk) disable iff (!rst_n)
        $rose(cs) |-> run_done)
        else $error("chip select rose outside run_done");

    a_busy_hold: assert property (@(posedge pll_clk) disable iff (!rst_n)
        busy |=> (busy || run_done))   // Drops only at the end of a run
        else $error("busy dropped before run_done");

    a_done_single: assert property (@(posedge pll_clk) disable iff (!rst_n)
        run_done |=> !run_done)
        else $error("run_done high in two consecutive cycles");

endmodule

bind spi_loop_top spi_loop_checker u_checker (
    .pll_clk   (pll_clk),
    .rst_n     (rst_n),
    .lane_start(lane_start),
    .cs        (cs),
    .busy      (busy),
    .run_done  (run_done)
);

// File: spi_loop_tb.sv
// Testbench for the SPI loopback self-test, runs from a cases file plus random runs
`timescale 1ns/100ps

module spi_loop_tb;
    import spi_loop_pkg::*;

    logic                          pll_clk;
    logic                          rst_n;
    logic                          start;
    run_cfg_t                      cfg;
    lane_pattern_t [num_lanes-1:0] patterns;
    logic                          ext_loop;
    logic                          miso;
    logic                          sclk;
    logic                          mosi;
    logic                          cs;
    lane_result_t [num_lanes-1:0]  results;
    logic                          run_done;
    logic                          busy;

    int                errors;
    int                timeouts;
    int                done_count;  // run_done pulses seen
    int                seed;
    int                line_sel;    // 0 internal, 1 stuck high, 2 line slave
    logic [1:0]        line_mode;
    logic [data_w-1:0] line_byte;   // Byte the line slave returns
    logic [data_w-1:0] mosi_byte;   // Lane 0 MOSI as seen on the pins
    int                mosi_edges;  // Sampling edges in the current frame

    spi_loop_top dut (
        .pll_clk (pll_clk),
        .rst_n   (rst_n),
        .start   (start),
        .cfg     (cfg),
        .patterns(patterns),
        .ext_loop(ext_loop),
        .miso    (miso),
        .sclk    (sclk),
        .mosi    (mosi),
        .cs      (cs),
        .results (results),
        .run_done(run_done),
        .busy    (busy)
    );

    initial begin
        pll_clk = 1'b0;
        forever #5 pll_clk = ~pll_clk;
    end

    initial begin
        done_count = 0;
        forever begin
            @(negedge pll_clk);
            if (run_done)
                done_count++;
        end
    end

    // External line model, updates miso on falling edges only
    initial begin
        logic              armed;
        logic              prev;
        logic [data_w-1:0] sh;
        int                left;
        miso  = 1'b0;
        armed = 1'b0;
        prev  = 1'b0;
        sh    = '0;
        left  = 0;
        forever begin
            @(negedge pll_clk);
            if (line_sel == 1) begin
                miso = 1'b1;                        // Broken loop, line pulled high
            end else if (line_sel == 2 && !cs) begin
                if (!armed && sclk == line_mode[1]) begin
                    armed = 1'b1;                   // SCK settled at idle for this mode
                    prev  = sclk;
                    sh    = line_byte;
                    left  = data_w;
                    if (!line_mode[0]) begin
                        miso = sh[data_w-1];        // CPHA 0 presents MSB at CS low
                        sh   = sh << 1;
                        left = left - 1;
                    end
                end else if (armed && sclk != prev) begin
                    prev = sclk;
                    // Launch on leading edge for CPHA 1, trailing for CPHA 0
                    if (((sclk != line_mode[1]) == line_mode[0]) && left > 0) begin
                        miso = sh[data_w-1];
                        sh   = sh << 1;
                        left = left - 1;
                    end
                end
            end else begin
                armed = 1'b0;
                miso  = 1'b0;
            end
        end
    end

    // Lane 0 MOSI monitor, shifts on the sampling edge of the mode
    initial begin
        logic armed;
        logic prev;
        mosi_byte  = '0;
        mosi_edges = 0;
        armed      = 1'b0;
        prev       = 1'b0;
        forever begin
            @(negedge pll_clk);
            if (cs) begin
                armed = 1'b0;
            end else if (!armed) begin
                if (sclk == line_mode[1]) begin
                    armed      = 1'b1;              // SCK at idle level of the run mode
                    prev       = sclk;
                    mosi_byte  = '0;
                    mosi_edges = 0;
                end
            end else if (sclk != prev) begin
                prev = sclk;
                // Sample on leading edge for CPHA 0, trailing for CPHA 1
                if ((sclk != line_mode[1]) != line_mode[0]) begin
                    mosi_byte = {mosi_byte[data_w-2:0], mosi};
                    mosi_edges++;
                end
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %0s expected %0h actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    // One run from start pulse to run_done, optional start pulse while busy
    task automatic run_case(input string name, input logic [1:0] mode,
                            input logic [baud_w-1:0] div, input int sel,
                            input lane_pattern_t [num_lanes-1:0] pat,
                            input logic [num_lanes-1:0] exp_mask, input bit poke_busy);
        int                   cycles;
        int                   limit;
        int                   done_before;
        logic [num_lanes-1:0] pass_mask;
        logic [data_w-1:0]    exp_mrx;
        @(negedge pll_clk);
        check_value({name, " cs high before run"}, 32'(1'b1), 32'(cs));
        line_sel    = sel;
        line_mode   = mode;
        line_byte   = pat[0].slave_tx;
        ext_loop    = (sel != 0);
        cfg         = '{mode: spi_mode_e'(mode), baud_div: div};
        patterns    = pat;
        done_before = done_count;
        start       = 1'b1;
        limit       = 20 * (int'(div) + 2) + 40;  // 18 half periods plus margin
        cycles      = 0;
        @(negedge pll_clk);
        start = 1'b0;
        while (!run_done && cycles < limit) begin
            check_value({name, " cs low while busy"}, 32'(1'b0), 32'(cs));
            check_value({name, " busy during run"}, 32'(1'b1), 32'(busy));
            @(negedge pll_clk);
            cycles++;
            start = poke_busy && (cycles == 3);   // Must be dropped
            if (start) begin
                patterns = ~pat;
                cfg.mode = spi_mode_e'(~mode);
            end
        end
        start = 1'b0;
        if (!run_done) begin
            $display("Timeout: case %0s got no run_done within %0d cycles", name, limit);
            timeouts++;
            return;
        end
        check_value({name, " cs high at run_done"}, 32'(1'b1), 32'(cs));
        check_value({name, " busy low at run_done"}, 32'(1'b0), 32'(busy));
        check_value({name, " sclk idle level"}, 32'(mode[1]), 32'(sclk));
        check_value({name, " mosi sampling edges"}, 32'(data_w), 32'(mosi_edges));
        check_value({name, " mosi byte"}, 32'(pat[0].master_tx), 32'(mosi_byte));
        for (int k = 0; k < num_lanes; k++) begin
            exp_mrx = pat[k].slave_tx;
            if (k == 0 && sel == 1)
                exp_mrx = '1;                      // Stuck-high line reads all ones
            check_value($sformatf("%0s lane%0d master_rx", name, k),
                        32'(exp_mrx), 32'(results[k].master_rx));
            check_value($sformatf("%0s lane%0d slave_rx", name, k),
                        32'(pat[k].master_tx), 32'(results[k].slave_rx));
            pass_mask[k] = results[k].pass;
        end
        check_value({name, " pass mask"}, 32'(exp_mask), 32'(pass_mask));
        repeat (3) @(negedge pll_clk);
        check_value({name, " run_done count"}, 32'(done_before + 1), 32'(done_count));
        check_value({name, " idle after run"}, 32'(1'b0), 32'(busy));
    endtask

    initial begin
        int                            fd;
        int                            n;
        int                            mode_in;
        int                            div_in;
        int                            sel_in;
        string                         line;
        string                         name;
        logic [data_w-1:0]             mtx [num_lanes];
        logic [data_w-1:0]             stx [num_lanes];
        logic [num_lanes-1:0]          mask_in;
        lane_pattern_t [num_lanes-1:0] pat;
        logic [31:0]                   rnd;
        errors    = 0;
        timeouts  = 0;
        seed      = 89420;
        rst_n     = 1'b0;
        start     = 1'b0;
        cfg       = '0;
        patterns  = '0;
        ext_loop  = 1'b0;
        line_sel  = 0;
        line_mode = 2'b00;
        line_byte = '0;
        repeat (4) @(negedge pll_clk);
        rst_n = 1'b1;
        @(negedge pll_clk);
        check_value("reset cs", 32'(1'b1), 32'(cs));
        check_value("reset busy", 32'(1'b0), 32'(busy));
        check_value("reset run_done", 32'(1'b0), 32'(run_done));
        check_value("reset results", 32'(1'b0), 32'(results != '0));

        fd = $fopen("spi_loop_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the cases file spi_loop_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd) && timeouts == 0) begin
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %d %d %d %h %h %h %h %h %h %h %h %h", name,
                                mode_in, div_in, sel_in, mtx[0], mtx[1], mtx[2], mtx[3],
                                stx[0], stx[1], stx[2], stx[3], mask_in);
                    if (n == 13) begin
                        for (int k = 0; k < num_lanes; k++)
                            pat[k] = '{master_tx: mtx[k], slave_tx: stx[k]};
                        run_case(name, 2'(mode_in), baud_w'(div_in), sel_in, pat,
                                 mask_in, 1'b0);
                    end else if (n > 0) begin
                        $display("Malformed line in the cases file: %0s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end

        // Random patterns, internal loop, extra start while busy
        for (int r = 0; r < 4 && timeouts == 0; r++) begin
            rnd = $random(seed);
            pat = {$random(seed), $random(seed)};
            run_case($sformatf("random%0d", r), rnd[1:0], baud_w'(2) + baud_w'(rnd[6:4]),
                     0, pat, '1, 1'b1);
        end

        $display("Errors: %0d check, %0d timeout", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: spi_loop_cases.txt
# name mode baud_div line(0 internal,1 miso stuck high,2 line slave)
# master_tx lanes 0..3, slave_tx lanes 0..3 (hex), expected pass mask (hex, bit k = lane k)
mode0_div2   0 2 0 A5 3C 00 FF 5A C3 FF 00 F
mode1_div2   1 2 0 A5 3C 00 FF 5A C3 FF 00 F
mode2_div3   2 3 0 81 7E 24 DB 18 E7 42 BD F
mode3_div2   3 2 0 01 80 FE 7F 10 08 EF F7 F
mode0_div7   0 7 0 12 34 56 78 9A BC DE F0 F
mode1_div5   1 5 0 F0 0F CC 33 AA 55 99 66 F
mode2_div4   2 4 0 C3 5A FF 00 00 FF 5A C3 F
mode3_div9   3 9 0 6B 2D 90 47 B4 D2 09 74 F
lanes_mixed  0 4 0 00 FF 5A C3 C3 5A FF 00 F
lanes_mixed3 3 3 0 5A C3 00 FF FF 00 C3 5A F
ext_high_m0  0 3 1 A5 11 22 33 5A 44 55 66 E
ext_high_m3  3 2 1 3C 77 88 99 C3 AA BB CC E
ext_high_ff  2 3 1 0F 01 02 03 FF 04 05 06 F
ext_slave_m0 0 3 2 A5 11 22 33 96 44 55 66 F
ext_slave_m1 1 2 2 5A 12 34 56 69 78 9A BC F
ext_slave_m2 2 4 2 C3 DE AD BE 3C EF 01 23 F
ext_slave_m3 3 3 2 81 45 67 89 7E AB CD EF F

// File: spi_loop_top.f
spi_loop_pkg.sv
spi_master.sv
spi_slave.sv
loop_sequencer.sv
loop_result_collector.sv
spi_loop_top.sv
spi_loop_checker.sv
spi_loop_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := spi_loop_tb
FILELIST  := spi_loop_top.f
LOG       := sim.log
FAIL_MSG  := Testbench failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation finished without failure"

clean:
	rm -rf obj_dir $(LOG)
